// ==== list.f ====
logic/dump_cfg_pkg.sv
logic/console_pkg.sv
logic/flash_word_if.sv
logic/serial_char_if.sv
logic/spi_flash_reader.sv
logic/uart_tx.sv
logic/dump_sequencer.sv
logic/flash_dump_top.sv
verif/spi_flash_model.sv
verif/tb_flash_dump.sv

// ==== logic/console_pkg.sv ====
/*
 * console line definitions
 * ascii codes of the dump line, the line length
 * and the states of the dump sequencer
 */

package console_pkg;

	// --------------------
	// characters
	// --------------------
	localparam dump_cfg_pkg::flash_word_t char_space = 8'h20;
	localparam dump_cfg_pkg::flash_word_t char_one = 8'h31;
	localparam dump_cfg_pkg::flash_word_t char_zero = 8'h30;
	// carriage return, then line feed
	localparam dump_cfg_pkg::flash_word_t char_cr = 8'h0d;
	localparam dump_cfg_pkg::flash_word_t char_lf = 8'h0a;

	// raw byte, space, eight digits, cr, lf
	localparam int line_chars = 12;

	// --------------------
	// sequencer states
	// --------------------
	typedef enum logic [2:0] {
		pause,
		read_byte,
		send_raw,
		send_space,
		send_bit,
		send_cr,
		send_lf
	} dump_state_t;

endpackage

// ==== logic/dump_cfg_pkg.sv ====
/*
 * flash dump configuration
 * word and address sizes of the spi flash, the read command
 * and helpers that turn clock rates into cycle counts
 */

package dump_cfg_pkg;

	// one flash word, also one console character
	localparam int word_bits = 8;
	// bytes of address sent after the command
	localparam int addr_words = 3;

	typedef logic [word_bits*addr_words-1:0] flash_addr_t;
	typedef logic [word_bits-1:0] flash_word_t;

	// standard serial read command
	localparam flash_word_t flash_cmd_read = 8'h03;

	// --------------------
	// divider helpers
	// --------------------

	// main clock cycles per serial bit
	function automatic int cycles_per_bit(input int main_hz, input int target_hz);
		return main_hz / target_hz;
	endfunction

	// main clock cycles per half period of the flash clock, at least one
	function automatic int half_period_cycles(input int main_hz, input int target_hz);
		int n;
		n = main_hz / (2 * target_hz);
		return (n < 1) ? 1 : n;
	endfunction

endpackage

// ==== logic/dump_sequencer.sv ====
/*
 * dump sequencer
 * pauses, fetches one flash byte and sends it as a console line:
 * raw byte, space, eight binary digits msb first, cr, lf
 */

`timescale 1ns/10ps

module dump_sequencer #(
	parameter int PAUSE_CYCLES = 6_750_000
) (
	input logic clk27,
	input logic rst,
	flash_word_if.requester flash,
	serial_char_if.source console
);

	localparam int pause_w = $clog2(PAUSE_CYCLES + 1);
	localparam logic [pause_w-1:0] pause_last = pause_w'(PAUSE_CYCLES - 1);
	localparam int idx_w = $clog2(dump_cfg_pkg::word_bits);

	console_pkg::dump_state_t state;
	dump_cfg_pkg::flash_addr_t addr_q;
	dump_cfg_pkg::flash_word_t byte_q;
	logic [idx_w-1:0] bit_idx;
	logic [pause_w-1:0] pause_ctr;

	// --------------------
	// state machine
	// --------------------
	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			state <= console_pkg::pause;
			addr_q <= '0;
			bit_idx <= '0;
			pause_ctr <= '0;
		end else begin
			case (state)
				console_pkg::pause: begin
					if (pause_ctr == pause_last) begin
						state <= console_pkg::read_byte;
					end else begin
						pause_ctr <= pause_ctr + 1'b1;
					end
				end
				console_pkg::read_byte: begin
					// byte captured, next line reads the next address
					if (flash.word_ready) begin
						addr_q <= addr_q + 1'b1;
						state <= console_pkg::send_raw;
					end
				end
				console_pkg::send_raw: begin
					if (console.word_finished) begin
						state <= console_pkg::send_space;
					end
				end
				console_pkg::send_space: begin
					if (console.word_finished) begin
						// highest bit first
						bit_idx <= idx_w'(dump_cfg_pkg::word_bits - 1);
						state <= console_pkg::send_bit;
					end
				end
				console_pkg::send_bit: begin
					if (console.word_finished) begin
						if (bit_idx == '0) begin
							state <= console_pkg::send_cr;
						end else begin
							bit_idx <= bit_idx - 1'b1;
						end
					end
				end
				console_pkg::send_cr: begin
					if (console.word_finished) begin
						state <= console_pkg::send_lf;
					end
				end
				console_pkg::send_lf: begin
					// line done, start a fresh pause
					if (console.word_finished) begin
						pause_ctr <= '0;
						state <= console_pkg::pause;
					end
				end
				default: begin
					state <= console_pkg::pause;
				end
			endcase
		end
	end

	// byte of the current line
	always_ff @(posedge clk27) begin
		if (state == console_pkg::read_byte && flash.word_ready) begin
			byte_q <= flash.data;
		end
	end

	// --------------------
	// outputs
	// --------------------
	assign flash.enable = (state == console_pkg::read_byte);
	assign flash.addr = addr_q;
	assign console.enable = (state != console_pkg::pause) && (state != console_pkg::read_byte);

	always_comb begin
		case (state)
			console_pkg::send_raw: console.char = byte_q;
			console_pkg::send_bit: console.char = byte_q[bit_idx] ?
				console_pkg::char_one : console_pkg::char_zero;
			console_pkg::send_cr: console.char = console_pkg::char_cr;
			console_pkg::send_lf: console.char = console_pkg::char_lf;
			default: console.char = console_pkg::char_space;
		endcase
	end

	// flash access and console output never overlap
	a_one_channel: assert property (@(posedge clk27) disable iff (rst)
		!(flash.enable && console.enable));

	// char held while the transmitter is busy with it
	a_char_stable: assert property (@(posedge clk27) disable iff (rst)
		console.enable && !console.ready && !console.word_finished |=> $stable(console.char));

endmodule

// ==== logic/flash_dump_top.sv ====
/*
 * flash dump top level
 * reads the spi flash byte by byte and prints each byte
 * as one line on the serial console
 */

`timescale 1ns/10ps

module flash_dump_top #(
	parameter int MAIN_CLK_HZ = 27_000_000,
	parameter int FLASH_CLK_HZ = 10_000_000,
	parameter int SERIAL_CLK_HZ = 115_200,
	// 250 ms at the main clock
	parameter int PAUSE_CYCLES = 6_750_000
) (
	input logic clk27,
	input logic rst,
	input logic flash_in,
	output logic serial_tx,
	output logic flash_clk,
	output logic flash_sel,
	output logic flash_out
);

	// sequencer to flash reader
	flash_word_if flash_bus ();
	// sequencer to serial transmitter
	serial_char_if char_bus ();

	dump_sequencer #(
		.PAUSE_CYCLES(PAUSE_CYCLES)
	) dump_sequencer_i (
		.clk27(clk27),
		.rst(rst),
		.flash(flash_bus.requester),
		.console(char_bus.source)
	);

	spi_flash_reader #(
		.MAIN_CLK_HZ(MAIN_CLK_HZ),
		.FLASH_CLK_HZ(FLASH_CLK_HZ)
	) spi_flash_reader_i (
		.clk27(clk27),
		.rst(rst),
		.flash_in(flash_in),
		.req(flash_bus.reader),
		.flash_clk(flash_clk),
		.flash_sel(flash_sel),
		.flash_out(flash_out)
	);

	uart_tx #(
		.MAIN_CLK_HZ(MAIN_CLK_HZ),
		.SERIAL_CLK_HZ(SERIAL_CLK_HZ)
	) uart_tx_i (
		.clk27(clk27),
		.rst(rst),
		.tx(char_bus.sink),
		.serial_tx(serial_tx)
	);

endmodule

// ==== logic/flash_word_if.sv ====
/*
 * flash word request channel
 * sequencer asks for one byte at an address,
 * the reader answers with the byte and a one cycle ready pulse
 */

`timescale 1ns/10ps

interface flash_word_if;

	// held high by the requester until word_ready
	logic enable;
	// stable while enable is high
	dump_cfg_pkg::flash_addr_t addr;
	// valid in the word_ready cycle
	dump_cfg_pkg::flash_word_t data;
	logic word_ready;

	modport requester (
		output enable,
		output addr,
		input data,
		input word_ready
	);

	modport reader (
		input enable,
		input addr,
		output data,
		output word_ready
	);

endinterface

// ==== logic/serial_char_if.sv ====
/*
 * serial character channel
 * sequencer offers one character, the transmitter takes it
 * while idle and pulses word_finished after the stop bit
 */

`timescale 1ns/10ps

interface serial_char_if;

	// held high together with a stable char
	logic enable;
	dump_cfg_pkg::flash_word_t char;
	// transmitter idle level
	logic ready;
	// last cycle of the stop bit
	logic word_finished;

	modport source (
		output enable,
		output char,
		input ready,
		input word_finished
	);

	modport sink (
		input enable,
		input char,
		output ready,
		output word_finished
	);

endinterface

// ==== logic/spi_flash_reader.sv ====
/*
 * spi flash reader
 * runs one read command (0x03 + 24 bit address) in mode 0,
 * msb first, and returns the single data byte that follows
 */

`timescale 1ns/10ps

module spi_flash_reader #(
	parameter int MAIN_CLK_HZ = 27_000_000,
	parameter int FLASH_CLK_HZ = 10_000_000
) (
	input logic clk27,
	input logic rst,
	input logic flash_in,
	flash_word_if.reader req,
	output logic flash_clk,
	output logic flash_sel,
	output logic flash_out
);

	localparam int half_cycles = dump_cfg_pkg::half_period_cycles(MAIN_CLK_HZ, FLASH_CLK_HZ);
	localparam int half_w = (half_cycles > 1) ? $clog2(half_cycles) : 1;
	// command byte plus address bytes
	localparam int cmd_bits = dump_cfg_pkg::word_bits * (dump_cfg_pkg::addr_words + 1);
	// whole frame, 40 bits
	localparam int frame_bits = cmd_bits + dump_cfg_pkg::word_bits;
	localparam int ctr_w = $clog2(frame_bits);
	localparam logic [half_w-1:0] half_last = half_w'(half_cycles - 1);
	localparam logic [ctr_w-1:0] bit_last = ctr_w'(frame_bits - 1);
	localparam logic [ctr_w-1:0] read_first = ctr_w'(cmd_bits);

	logic [half_w-1:0] half_ctr;
	logic [ctr_w-1:0] bit_ctr;
	logic [cmd_bits-1:0] cmd_shift;
	dump_cfg_pkg::flash_word_t data_shift;
	logic sel_q;
	logic clk_q;
	logic ready_q;
	logic half_done;
	logic sample_en;

	// end of a half period while selected
	assign half_done = !sel_q && (half_ctr == half_last);
	// rising edge of flash_clk during the data byte
	assign sample_en = half_done && !clk_q && (bit_ctr >= read_first);

	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			sel_q <= 1'b1;
			clk_q <= 1'b0;
			ready_q <= 1'b0;
			half_ctr <= '0;
			bit_ctr <= '0;
			cmd_shift <= '0;
		end else begin
			// ready is a single cycle pulse
			ready_q <= 1'b0;
			if (sel_q) begin
				// skip the pulse cycle, enable is still high there
				if (req.enable && !ready_q) begin
					sel_q <= 1'b0;
					clk_q <= 1'b0;
					half_ctr <= '0;
					bit_ctr <= '0;
					cmd_shift <= {dump_cfg_pkg::flash_cmd_read, req.addr};
				end
			end else if (half_done) begin
				half_ctr <= '0;
				if (!clk_q) begin
					// rising edge, flash samples our bit
					clk_q <= 1'b1;
				end else begin
					// falling edge, next bit out or end of frame
					clk_q <= 1'b0;
					if (bit_ctr == bit_last) begin
						sel_q <= 1'b1;
						ready_q <= 1'b1;
					end else begin
						bit_ctr <= bit_ctr + 1'b1;
						cmd_shift <= {cmd_shift[cmd_bits-2:0], 1'b0};
					end
				end
			end else begin
				half_ctr <= half_ctr + 1'b1;
			end
		end
	end

	// incoming data byte, msb first
	always_ff @(posedge clk27) begin
		if (sample_en) begin
			data_shift <= {data_shift[dump_cfg_pkg::word_bits-2:0], flash_in};
		end
	end

	assign flash_clk = clk_q;
	assign flash_sel = sel_q;
	// zero once the command and address have gone out
	assign flash_out = cmd_shift[cmd_bits-1];
	assign req.data = data_shift;
	assign req.word_ready = ready_q;

	// mode 0 bus idles with the clock low
	a_clk_idle_low: assert property (@(posedge clk27) disable iff (rst)
		flash_sel |-> !flash_clk);

	a_ready_pulse: assert property (@(posedge clk27) disable iff (rst)
		req.word_ready |=> !req.word_ready);

endmodule

// ==== logic/uart_tx.sv ====
/*
 * asynchronous serial transmitter
 * sends one 8n1 character per request, low bit first
 */

`timescale 1ns/10ps

module uart_tx #(
	parameter int MAIN_CLK_HZ = 27_000_000,
	parameter int SERIAL_CLK_HZ = 115_200
) (
	input logic clk27,
	input logic rst,
	serial_char_if.sink tx,
	output logic serial_tx
);

	localparam int bit_time = dump_cfg_pkg::cycles_per_bit(MAIN_CLK_HZ, SERIAL_CLK_HZ);
	localparam int ctr_w = (bit_time > 1) ? $clog2(bit_time) : 1;
	// start bit, data bits, stop bit
	localparam int frame_len = dump_cfg_pkg::word_bits + 2;
	localparam int idx_w = $clog2(frame_len);
	localparam logic [ctr_w-1:0] cycle_last = ctr_w'(bit_time - 1);
	localparam logic [idx_w-1:0] bit_last = idx_w'(frame_len - 1);

	logic busy;
	logic [ctr_w-1:0] cycle_ctr;
	logic [idx_w-1:0] bit_idx;
	logic [frame_len-1:0] frame;
	logic bit_end;

	// last cycle of the current bit
	assign bit_end = busy && (cycle_ctr == cycle_last);

	always_ff @(posedge clk27 or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			cycle_ctr <= '0;
			bit_idx <= '0;
			// all ones keeps the line at mark level
			frame <= '1;
		end else if (!busy) begin
			if (tx.enable) begin
				busy <= 1'b1;
				cycle_ctr <= '0;
				bit_idx <= '0;
				frame <= {1'b1, tx.char, 1'b0};
			end
		end else if (bit_end) begin
			cycle_ctr <= '0;
			// shift in ones behind the stop bit
			frame <= {1'b1, frame[frame_len-1:1]};
			if (bit_idx == bit_last) begin
				busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 1'b1;
			end
		end else begin
			cycle_ctr <= cycle_ctr + 1'b1;
		end
	end

	assign serial_tx = frame[0];
	assign tx.ready = !busy;
	// end of the stop bit, next start bit may follow right after
	assign tx.word_finished = bit_end && (bit_idx == bit_last);

	// finish only ends a running transfer, idle follows it
	a_finish_then_idle: assert property (@(posedge clk27) disable iff (rst)
		tx.word_finished |-> !tx.ready ##1 tx.ready);

endmodule

// ==== verif/spi_flash_model.sv ====
/*
 * behavioral spi flash
 * answers mode 0 read commands from a small memory filled by an lcg
 * and counts protocol errors on the bus
 */

`timescale 1ns/10ps

module spi_flash_model #(
	parameter int SEED = 1,
	parameter int MEM_BYTES = 64
) (
	input logic flash_clk,
	input logic flash_sel,
	input logic flash_out,
	output logic flash_in,
	output int protocol_errors,
	output int frames_seen
);

	logic [7:0] mem [MEM_BYTES];
	// command byte and address, msb first
	logic [31:0] cmd_shift;
	logic [7:0] data_q;
	int bit_cnt;
	int next_addr;
	bit in_frame;

	// 32 bit lcg, classic constants
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	initial begin : fill
		logic [31:0] state;
		int a;
		state = 32'(SEED);
		for (a = 0; a < MEM_BYTES; a++) begin
			state = lcg_next(state);
			mem[a] = state[23:16];
		end
		flash_in = 1'b0;
		protocol_errors = 0;
		frames_seen = 0;
		next_addr = 0;
		bit_cnt = 0;
		in_frame = 1'b0;
	end

	// --------------------
	// frame start
	// --------------------
	always @(negedge flash_sel) begin
		in_frame = 1'b1;
		bit_cnt = 0;
		cmd_shift = '0;
	end

	// flash samples on the rising edge
	always @(posedge flash_clk) begin
		if (in_frame) begin
			if (bit_cnt < 32) begin
				cmd_shift = {cmd_shift[30:0], flash_out};
			end
			bit_cnt++;
			// address complete, fetch the byte
			if (bit_cnt == 32) begin
				data_q = mem[cmd_shift[23:0] % MEM_BYTES];
			end
		end
	end

	// data out on the falling edge, msb first
	always @(negedge flash_clk) begin
		if (in_frame && bit_cnt >= 32 && bit_cnt < 40) begin
			flash_in <= data_q[39 - bit_cnt];
		end
	end

	// --------------------
	// frame end checks
	// --------------------
	always @(posedge flash_sel) begin
		if (in_frame) begin
			in_frame = 1'b0;
			assert (bit_cnt == 40) else begin
				protocol_errors++;
				$display("flash frame had %0d clock pulses instead of 40", bit_cnt);
			end
			assert (cmd_shift[31:24] == 8'h03) else begin
				protocol_errors++;
				$display("flash command byte 0x%02h is not a read", cmd_shift[31:24]);
			end
			assert (cmd_shift[23:0] == 24'(next_addr)) else begin
				protocol_errors++;
				$display("flash address %0d out of sequence, expected %0d",
					cmd_shift[23:0], next_addr);
			end
			next_addr++;
			frames_seen++;
		end
	end

endmodule

// ==== verif/tb_flash_dump.sv ====
/*
 * flash dump testbench
 * decodes the serial console, checks every line against the flash
 * contents and checks the pause between lines
 */

`timescale 1ns/10ps

module tb_flash_dump;

	localparam int main_clk_hz = 27_000_000;
	localparam int serial_clk_hz = 3_375_000;
	localparam int flash_clk_hz = 6_750_000;
	localparam int pause_cycles = 200;
	localparam int seed = 26187;
	localparam int mem_bytes = 64;
	localparam int line_count = 6;
	localparam int reset_cycles = 16;
	// 8 cycles per serial bit
	localparam int bit_cycles = main_clk_hz / serial_clk_hz;
	localparam int half_bit = bit_cycles / 2;
	// pause, 40 flash bits of 4 cycles, 12 characters of 10 bits, slack
	localparam int line_cycles = pause_cycles + 40 * 4 + 12 * 10 * bit_cycles + 40;
	localparam int max_cycles = reset_cycles + (line_count + 2) * line_cycles;

	logic clk27;
	logic rst;
	logic flash_in;
	logic serial_tx;
	logic flash_clk;
	logic flash_sel;
	logic flash_out;
	int protocol_errors;
	int frames_seen;

	int cycle_count = 0;
	int errors = 0;
	int errors_base = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	// decoded characters and the cycle each stop bit ends
	logic [7:0] rx_chars [$];
	int rx_ends [$];
	// pause window, open from reset release and after each lf
	bit gap_open = 1'b1;
	int gap_start = 0;
	int gaps_done = 0;

	flash_dump_top #(
		.MAIN_CLK_HZ(main_clk_hz),
		.FLASH_CLK_HZ(flash_clk_hz),
		.SERIAL_CLK_HZ(serial_clk_hz),
		.PAUSE_CYCLES(pause_cycles)
	) flash_dump_top_i (
		.clk27(clk27),
		.rst(rst),
		.flash_in(flash_in),
		.serial_tx(serial_tx),
		.flash_clk(flash_clk),
		.flash_sel(flash_sel),
		.flash_out(flash_out)
	);

	spi_flash_model #(
		.SEED(seed),
		.MEM_BYTES(mem_bytes)
	) flash_model_i (
		.flash_clk(flash_clk),
		.flash_sel(flash_sel),
		.flash_out(flash_out),
		.flash_in(flash_in),
		.protocol_errors(protocol_errors),
		.frames_seen(frames_seen)
	);

	always #2 clk27 = ~clk27;

	// --------------------
	// reference and bookkeeping
	// --------------------

	// character at position index of the line for one byte
	function automatic logic [7:0] expected_line(input logic [7:0] data, input int index);
		logic [7:0] c;
		case (index)
			0: c = data;
			1: c = 8'h20;
			10: c = 8'h0d;
			11: c = 8'h0a;
			// digits, highest bit first
			default: c = data[9 - index] ? 8'h31 : 8'h30;
		endcase
		return c;
	endfunction

	task automatic finish_test(input string name);
		if (errors == errors_base) begin
			tests_passed++;
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: fail, %0d errors", name, errors - errors_base);
		end
		errors_base = errors;
	endtask

	// --------------------
	// serial decoder
	// --------------------
	initial begin : decode
		logic [7:0] data;
		int i;
		forever begin
			@(posedge clk27);
			if (!rst && serial_tx === 1'b0) begin
				// middle of the start bit
				repeat (half_bit) @(posedge clk27);
				assert (serial_tx === 1'b0) else begin
					errors++;
					$display("framing error at %0t: start bit did not stay low", $time);
				end
				for (i = 0; i < 8; i++) begin
					repeat (bit_cycles) @(posedge clk27);
					data[i] = serial_tx;
				end
				repeat (bit_cycles) @(posedge clk27);
				assert (serial_tx === 1'b1) else begin
					errors++;
					$display("framing error at %0t: stop bit is low", $time);
				end
				rx_chars.push_back(data);
				rx_ends.push_back(cycle_count + half_bit);
			end
		end
	end

	// --------------------
	// line compare
	// --------------------
	initial begin : compare
		int line_idx;
		int char_idx;
		int end_cycle;
		logic [7:0] got;
		logic [7:0] exp;
		for (line_idx = 0; line_idx < line_count; line_idx++) begin
			for (char_idx = 0; char_idx < 12; char_idx++) begin
				wait (rx_chars.size() > 0);
				got = rx_chars.pop_front();
				end_cycle = rx_ends.pop_front();
				exp = expected_line(flash_model_i.mem[line_idx % mem_bytes], char_idx);
				assert (got == exp) else begin
					errors++;
					$display("FAILED t=%0t serial_tx char %0d of line %0d: expected 8'h%02h, got 8'h%02h",
						$time, char_idx, line_idx, exp, got);
				end
			end
			gap_start = end_cycle;
			gap_open = 1'b1;
		end
	end

	// --------------------
	// pause monitor
	// --------------------
	always @(posedge clk27) begin
		if (!rst && gap_open) begin
			if (!flash_sel) begin
				// next flash read has started
				assert (cycle_count - gap_start >= pause_cycles) else begin
					errors++;
					$display("FAILED t=%0t pause_cycles: expected at least %0d, got %0d",
						$time, pause_cycles, cycle_count - gap_start);
				end
				if (gaps_done == 0) begin
					finish_test("reset and first pause");
				end else begin
					finish_test($sformatf("line %0d and pause", gaps_done - 1));
				end
				gap_open = 1'b0;
				gaps_done++;
			end else begin
				assert (serial_tx === 1'b1) else begin
					errors++;
					$display("FAILED t=%0t serial_tx: expected 1, got %b", $time, serial_tx);
				end
				assert (flash_clk === 1'b0) else begin
					errors++;
					$display("FAILED t=%0t flash_clk: expected 0, got %b", $time, flash_clk);
				end
			end
		end
	end

	// timeout
	always @(posedge clk27) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// --------------------
	// main sequence
	// --------------------
	initial begin
		clk27 = 1'b0;
		rst = 1'b1;
		repeat (reset_cycles) @(posedge clk27);
		rst <= 1'b0;
		gap_start = cycle_count;
		wait (gaps_done == line_count + 1);
		assert (protocol_errors == 0) else begin
			errors++;
			$display("flash model reported %0d protocol errors", protocol_errors);
		end
		assert (frames_seen == line_count) else begin
			errors++;
			$display("FAILED t=%0t frames_seen: expected %0d, got %0d",
				$time, line_count, frames_seen);
		end
		finish_test("flash protocol");
		$display("%0d tests, %0d passed, %0d failed, %0d errors",
			tests_passed + tests_failed, tests_passed, tests_failed, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
